/* build.f */
fc_data_pkg.sv
fc_ctrl_pkg.sv
fc_operand_reader.sv
fc_operand_fifo.sv
fc_mac_array.sv
fc_layer_top.sv
fc_layer_checker.sv
fc_layer_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and judge by the pass message
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module fc_layer_tb -f build.f -o fc_layer_sim &&
./obj_dir/fc_layer_sim | tee /dev/stderr | grep -q "Everything OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* fc_layer_tb.sv */
`timescale 1ns/1ps

module fc_layer_tb;

	localparam int LANE_W     = 8;
	localparam int NUM_CORES  = 4;
	localparam int ACC_W      = 32;
	localparam int AWIDTH     = 12;
	localparam int CNT_W      = 13;
	localparam int FIFO_DEPTH = 4;
	localparam int MEM_DEPTH  = 1 << AWIDTH;
	localparam int NUM_TESTS  = 6;
	localparam int RST_CYCLES = 5;

	// Node count, extra start pulse while busy, name
	int    tbl_cnt  [NUM_TESTS] = '{1, 16, 64, 40, 64, 7};
	logic  tbl_busy [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
	string tbl_name [NUM_TESTS] = '{"single node", "sixteen nodes", "sixty-four nodes",
		"start while busy", "back to back", "short after long"};

	logic                        clk       = 1'b0;
	logic                        reset_n   = 1'b0;
	logic                        i_run     = 1'b0;
	logic [CNT_W-1:0]            i_num_cnt = '0;
	logic [LANE_W-1:0]           node_q    = '0;
	logic [NUM_CORES*LANE_W-1:0] wgt_q     = '0;
	logic [AWIDTH-1:0]           node_addr;
	logic [AWIDTH-1:0]           wgt_addr;
	logic                        node_ce;
	logic                        wgt_ce;
	logic                        o_idle;
	logic                        o_read;
	logic                        o_write;
	logic                        o_done;
	logic [NUM_CORES*ACC_W-1:0]  o_result;
	logic [LANE_W-1:0]           node_mem [MEM_DEPTH];
	logic [NUM_CORES*LANE_W-1:0] wgt_mem  [MEM_DEPTH];
	integer                      seed        = 32'hcf98;
	int                          cycles      = 0;
	int                          cycle_limit = 0;
	int                          errors;
	int                          tests_ok;
	int                          tests_bad;

	always #4 clk = ~clk;

	fc_layer_top #(
		.LANE_W(LANE_W), .NUM_CORES(NUM_CORES), .ACC_W(ACC_W),
		.AWIDTH(AWIDTH), .CNT_W(CNT_W), .FIFO_DEPTH(FIFO_DEPTH)
	) dut (
		.clk(clk), .reset_n(reset_n), .i_run(i_run), .i_num_cnt(i_num_cnt),
		.o_node_addr(node_addr), .o_node_ce(node_ce),
		.o_wgt_addr(wgt_addr), .o_wgt_ce(wgt_ce),
		.i_node_q(node_q), .i_wgt_q(wgt_q),
		.o_idle(o_idle), .o_read(o_read), .o_write(o_write), .o_done(o_done),
		.o_result(o_result)
	);

	fc_layer_checker #(
		.LANE_W(LANE_W), .NUM_CORES(NUM_CORES), .ACC_W(ACC_W),
		.AWIDTH(AWIDTH), .CNT_W(CNT_W), .MEM_DEPTH(MEM_DEPTH)
	) u_checker (
		.clk(clk), .reset_n(reset_n), .i_run(i_run), .i_num_cnt(i_num_cnt),
		.i_idle(o_idle), .i_read(o_read), .i_write(o_write), .i_done(o_done),
		.i_result(o_result),
		.i_node_addr(node_addr), .i_wgt_addr(wgt_addr),
		.i_node_ce(node_ce), .i_wgt_ce(wgt_ce),
		.i_node_mem(node_mem), .i_wgt_mem(wgt_mem),
		.o_errors(errors), .o_tests_ok(tests_ok), .o_tests_bad(tests_bad)
	);

	// Memories with one cycle registered read
	always @(posedge clk) begin
		if (node_ce) node_q <= node_mem[node_addr];
		if (wgt_ce) wgt_q <= wgt_mem[wgt_addr];
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	task fill_memories;
		int a;
		for (a = 0; a < MEM_DEPTH; a++) begin
			node_mem[a] = LANE_W'($random(seed));
			wgt_mem[a]  = (NUM_CORES*LANE_W)'($random(seed));
		end
	endtask

	// Called 1 ns after a rising edge
	task pulse_run(input int cnt);
		i_num_cnt = CNT_W'(cnt);
		i_run     = 1'b1;
		@(posedge clk);
		#1;
		i_run     = 1'b0;
	endtask

	task wait_pass_end;
		do @(negedge clk); while (o_done !== 1'b1);
		while (o_idle !== 1'b1) @(negedge clk);
		@(posedge clk);
		#1;
	endtask

	initial begin
		int t;
		for (t = 0; t < NUM_TESTS; t++) cycle_limit += tbl_cnt[t] + 30;
		cycle_limit += RST_CYCLES + 10;
		repeat (RST_CYCLES) @(posedge clk);
		#1 reset_n = 1'b1;
		@(posedge clk);
		#1;
		for (t = 0; t < NUM_TESTS; t++) begin
			$display("Starting test %0d: %s", t, tbl_name[t]);
			fill_memories();
			pulse_run(tbl_cnt[t]);
			if (tbl_busy[t]) begin
				repeat (3) @(posedge clk);
				#1;
				pulse_run(tbl_cnt[t] / 2);  // Must be ignored
			end
			wait_pass_end();
		end
		repeat (2) @(posedge clk);
		$display("Tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_ok, tests_bad, errors);
		if (errors == 0 && tests_bad == 0 && tests_ok == NUM_TESTS) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* fc_layer_checker.sv */
`timescale 1ns/1ps

module fc_layer_checker #(
	parameter int LANE_W    = 8,
	parameter int NUM_CORES = 4,
	parameter int ACC_W     = 32,
	parameter int AWIDTH    = 12,
	parameter int CNT_W     = 13,
	parameter int MEM_DEPTH = 4096
) (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        i_run,
	input  logic [CNT_W-1:0]            i_num_cnt,
	input  logic                        i_idle,
	input  logic                        i_read,
	input  logic                        i_write,
	input  logic                        i_done,
	input  logic [NUM_CORES*ACC_W-1:0]  i_result,
	input  logic [AWIDTH-1:0]           i_node_addr,
	input  logic [AWIDTH-1:0]           i_wgt_addr,
	input  logic                        i_node_ce,
	input  logic                        i_wgt_ce,
	input  logic [LANE_W-1:0]           i_node_mem [MEM_DEPTH],
	input  logic [NUM_CORES*LANE_W-1:0] i_wgt_mem [MEM_DEPTH],
	output int                          o_errors,
	output int                          o_tests_ok,
	output int                          o_tests_bad
);

	logic [ACC_W-1:0]           exp_sum [NUM_CORES];
	logic [NUM_CORES*ACC_W-1:0] held_result = '0;
	int                         num_n       = 0;
	int                         read_cycles = 0;
	int                         test_num    = 0;
	int                         test_errors = 0;
	int                         errors      = 0;
	int                         tests_ok    = 0;
	int                         tests_bad   = 0;
	logic                       busy        = 1'b0;  // A pass is running
	logic                       holding     = 1'b0;  // Result must stay put
	logic                       wait_idle   = 1'b0;
	logic                       reset_seen  = 1'b0;
	logic                       prev_write  = 1'b0;  // o_write one cycle back

	assign o_errors    = errors;
	assign o_tests_ok  = tests_ok;
	assign o_tests_bad = tests_bad;

	task automatic compare_bit(input string name, input logic expected, input logic got);
		if (got !== expected) begin
			$display("Error: %s expected 0x%h got 0x%h", name, expected, got);
			errors++;
		end
	endtask

	task automatic compare_addr(
		input string             name,
		input int                expected,
		input logic [AWIDTH-1:0] got
	);
		if (got !== AWIDTH'(expected)) begin
			$display("Error: %s expected 0x%h got 0x%h", name, AWIDTH'(expected), got);
			test_errors++;
		end
	endtask

	// Sampled on the falling edge while DUT outputs are stable
	always @(negedge clk) begin
		int               a;
		int               k;
		logic [ACC_W-1:0] got;
		if (reset_n) begin
			if (!reset_seen) begin
				compare_bit("o_idle", 1'b1, i_idle);
				compare_bit("o_read", 1'b0, i_read);
				compare_bit("o_write", 1'b0, i_write);
				compare_bit("o_done", 1'b0, i_done);
				if (i_result !== '0) begin
					$display("Error: o_result after reset expected 0x0 got 0x%h", i_result);
					errors++;
				end
				reset_seen = 1'b1;
			end
			// Chip enables go with o_read in every cycle
			compare_bit("o_node_ce", i_read, i_node_ce);
			compare_bit("o_wgt_ce", i_read, i_wgt_ce);
			if (holding && i_result !== held_result) begin
				$display("Error: o_result held expected 0x%h got 0x%h", held_result, i_result);
				errors++;
				holding = 1'b0;
			end
			if (wait_idle) begin
				if (i_idle !== 1'b1) begin
					$display("o_idle did not return high after the end of test %0d", test_num - 1);
					errors++;
				end
				wait_idle = 1'b0;
			end
			// An accepted start fixes the sums from the memory contents
			if (i_run && i_idle) begin
				num_n = int'(i_num_cnt);
				for (k = 0; k < NUM_CORES; k++) exp_sum[k] = '0;
				for (a = 0; a < num_n; a++) begin
					for (k = 0; k < NUM_CORES; k++) begin
						exp_sum[k] = exp_sum[k] + ACC_W'(i_node_mem[a]) *
							ACC_W'(i_wgt_mem[a][k*LANE_W +: LANE_W]);
					end
				end
				busy        = 1'b1;
				holding     = 1'b0;
				read_cycles = 0;
				test_errors = 0;
			end
			// Addresses step from zero, one per read cycle
			if (busy && i_read) begin
				compare_addr("o_node_addr", read_cycles, i_node_addr);
				compare_addr("o_wgt_addr", read_cycles, i_wgt_addr);
				read_cycles++;
			end
			if (i_done) begin
				if (!busy) begin
					$display("o_done pulsed while no pass was running");
					errors++;
				end else begin
					for (k = 0; k < NUM_CORES; k++) begin
						got = i_result[k*ACC_W +: ACC_W];
						if (got !== exp_sum[k]) begin
							$display("Error: o_result[%0d] expected 0x%h got 0x%h",
								k, exp_sum[k], got);
							test_errors++;
						end
					end
					if (read_cycles != num_n) begin
						$display("o_read was high for %0d cycles in a pass of %0d nodes",
							read_cycles, num_n);
						test_errors++;
					end
					if (prev_write !== 1'b1) begin
						$display("o_write was not high in the cycle before o_done");
						test_errors++;
					end
					errors += test_errors;
					if (test_errors == 0) begin
						tests_ok++;
						$display("Test %0d with %0d nodes passed", test_num, num_n);
					end else begin
						tests_bad++;
						$display("Test %0d with %0d nodes failed", test_num, num_n);
					end
					test_num++;
					busy        = 1'b0;
					holding     = 1'b1;
					held_result = i_result;
					wait_idle   = 1'b1;
				end
			end
			prev_write = i_write;
		end
	end

endmodule

/* fc_layer_top.sv */
`timescale 1ns/1ps

module fc_layer_top
	import fc_data_pkg::*;
#(
	parameter int LANE_W     = DEF_LANE_W,
	parameter int NUM_CORES  = DEF_NUM_CORES,
	parameter int ACC_W      = DEF_ACC_W,
	parameter int AWIDTH     = DEF_AWIDTH,
	parameter int CNT_W      = DEF_CNT_W,
	parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          i_run,
	input  logic [CNT_W-1:0]              i_num_cnt,
	output logic [AWIDTH-1:0]             o_node_addr,
	output logic                          o_node_ce,
	output logic [AWIDTH-1:0]             o_wgt_addr,
	output logic                          o_wgt_ce,
	input  logic [LANE_W-1:0]             i_node_q,
	input  logic [NUM_CORES*LANE_W-1:0]   i_wgt_q,
	output logic                          o_idle,
	output logic                          o_read,
	output logic                          o_write,
	output logic                          o_done,
	output logic [NUM_CORES*ACC_W-1:0]    o_result
);

	logic                        run_accept;
	logic                        read_idle;
	logic                        push;
	logic                        push_last;
	logic [LANE_W-1:0]           push_node;
	logic [NUM_CORES*LANE_W-1:0] push_wgt;
	logic                        pop;
	logic                        not_empty;
	logic                        head_last;
	logic [LANE_W-1:0]           head_node;
	logic [NUM_CORES*LANE_W-1:0] head_wgt;

	// Start only when both sides are idle
	assign run_accept = i_run && o_idle;

	fc_operand_reader #(
		.LANE_W     (LANE_W),
		.NUM_CORES  (NUM_CORES),
		.AWIDTH     (AWIDTH),
		.CNT_W      (CNT_W)
	) u_reader (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_run       (run_accept),
		.i_num_cnt   (i_num_cnt),
		.i_node_q    (i_node_q),
		.i_wgt_q     (i_wgt_q),
		.o_node_addr (o_node_addr),
		.o_wgt_addr  (o_wgt_addr),
		.o_node_ce   (o_node_ce),
		.o_wgt_ce    (o_wgt_ce),
		.o_read      (o_read),
		.o_read_idle (read_idle),
		.o_push      (push),
		.o_push_last (push_last),
		.o_push_node (push_node),
		.o_push_wgt  (push_wgt)
	);

	fc_operand_fifo #(
		.LANE_W     (LANE_W),
		.NUM_CORES  (NUM_CORES),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_push      (push),
		.i_push_last (push_last),
		.i_pop       (pop),
		.i_push_node (push_node),
		.i_push_wgt  (push_wgt),
		.o_not_empty (not_empty),
		.o_head_last (head_last),
		.o_head_node (head_node),
		.o_head_wgt  (head_wgt)
	);

	fc_mac_array #(
		.LANE_W     (LANE_W),
		.NUM_CORES  (NUM_CORES),
		.ACC_W      (ACC_W)
	) u_mac_array (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_run       (run_accept),
		.i_read_idle (read_idle),
		.i_not_empty (not_empty),
		.i_head_last (head_last),
		.i_head_node (head_node),
		.i_head_wgt  (head_wgt),
		.o_pop       (pop),
		.o_write     (o_write),
		.o_done      (o_done),
		.o_idle      (o_idle),
		.o_result    (o_result)
	);

endmodule

/* fc_mac_array.sv */
`timescale 1ns/1ps

module fc_mac_array
	import fc_data_pkg::*;
	import fc_ctrl_pkg::*;
#(
	parameter int LANE_W    = DEF_LANE_W,
	parameter int NUM_CORES = DEF_NUM_CORES,
	parameter int ACC_W     = DEF_ACC_W
) (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          i_run,
	input  logic                          i_read_idle,
	input  logic                          i_not_empty,
	input  logic                          i_head_last,
	input  logic [LANE_W-1:0]             i_head_node,
	input  logic [NUM_CORES*LANE_W-1:0]   i_head_wgt,
	output logic                          o_pop,
	output logic                          o_write,
	output logic                          o_done,
	output logic                          o_idle,
	output logic [NUM_CORES*ACC_W-1:0]    o_result
);

	phase_t wr_phase;
	phase_t wr_phase_nxt;
	logic   p_valid;   // Product stage holds an entry
	logic   p_last;
	logic   acc_last;  // Last entry enters the accumulators

	// Head is taken whenever present as nothing pushes back
	assign o_pop = i_not_empty;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			p_valid <= 1'b0;
			p_last  <= 1'b0;
		end else begin
			p_valid <= o_pop;
			p_last  <= o_pop && i_head_last;
		end
	end

	assign acc_last = p_valid && p_last;

	// One multiplier and accumulator per neuron
	for (genvar k = 0; k < NUM_CORES; k++) begin : g_lane
		logic [LANE_W-1:0]   wgt_lane;
		logic [2*LANE_W-1:0] prod;
		logic [ACC_W-1:0]    acc;

		assign wgt_lane = i_head_wgt[k*LANE_W +: LANE_W];

		always_ff @(posedge clk) begin
			if (o_pop) begin
				prod <= i_head_node * wgt_lane;  // Unsigned
			end
		end

		always_ff @(posedge clk or negedge reset_n) begin
			if (!reset_n) begin
				acc <= '0;
			end else if (i_run && o_idle) begin
				acc <= '0;  // New pass starts from zero
			end else if (p_valid) begin
				acc <= acc + ACC_W'(prod);
			end
		end

		assign o_result[k*ACC_W +: ACC_W] = acc;
	end

	// Write state machine follows the accumulated data
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_phase <= PH_IDLE;
		end else begin
			wr_phase <= wr_phase_nxt;
		end
	end

	always_comb begin
		wr_phase_nxt = wr_phase;
		case (wr_phase)
			PH_IDLE: if (i_run) wr_phase_nxt = PH_RUN;
			PH_RUN:  if (acc_last) wr_phase_nxt = PH_DONE;
			PH_DONE: wr_phase_nxt = PH_IDLE;
			default: wr_phase_nxt = PH_IDLE;
		endcase
	end

	// Write side is the slower one, so it gives done
	assign o_idle  = i_read_idle && (wr_phase == PH_IDLE);
	assign o_write = (wr_phase == PH_RUN);
	assign o_done  = (wr_phase == PH_DONE);

endmodule

/* fc_operand_fifo.sv */
`timescale 1ns/1ps

module fc_operand_fifo
	import fc_data_pkg::*;
#(
	parameter int LANE_W     = DEF_LANE_W,
	parameter int NUM_CORES  = DEF_NUM_CORES,
	parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          i_push,
	input  logic                          i_push_last,
	input  logic                          i_pop,
	input  logic [LANE_W-1:0]             i_push_node,
	input  logic [NUM_CORES*LANE_W-1:0]   i_push_wgt,
	output logic                          o_not_empty,
	output logic                          o_head_last,
	output logic [LANE_W-1:0]             o_head_node,
	output logic [NUM_CORES*LANE_W-1:0]   o_head_wgt
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int OCC_W = $clog2(FIFO_DEPTH + 1);

	logic [LANE_W-1:0]           node_mem [FIFO_DEPTH];
	logic [NUM_CORES*LANE_W-1:0] wgt_mem  [FIFO_DEPTH];
	logic                        last_mem [FIFO_DEPTH];
	logic [PTR_W-1:0]            wr_ptr;
	logic [PTR_W-1:0]            rd_ptr;
	logic [OCC_W-1:0]            occ;
	logic                        do_pop;

	assign do_pop = i_pop && o_not_empty;  // Pop on empty is dropped

	// Entry storage
	always_ff @(posedge clk) begin
		if (i_push) begin
			node_mem[wr_ptr] <= i_push_node;
			wgt_mem[wr_ptr]  <= i_push_wgt;
			last_mem[wr_ptr] <= i_push_last;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (i_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy count where push and pop may share a cycle
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			occ <= '0;
		end else begin
			case ({i_push, do_pop})
				2'b10:   occ <= occ + 1'b1;
				2'b01:   occ <= occ - 1'b1;
				default: occ <= occ;
			endcase
		end
	end

	assign o_not_empty = (occ != '0);
	assign o_head_node = node_mem[rd_ptr];
	assign o_head_wgt  = wgt_mem[rd_ptr];
	assign o_head_last = last_mem[rd_ptr];

endmodule

/* fc_operand_reader.sv */
`timescale 1ns/1ps

module fc_operand_reader
	import fc_data_pkg::*;
	import fc_ctrl_pkg::*;
#(
	parameter int LANE_W    = DEF_LANE_W,
	parameter int NUM_CORES = DEF_NUM_CORES,
	parameter int AWIDTH    = DEF_AWIDTH,
	parameter int CNT_W     = DEF_CNT_W
) (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          i_run,
	input  logic [CNT_W-1:0]              i_num_cnt,
	input  logic [LANE_W-1:0]             i_node_q,
	input  logic [NUM_CORES*LANE_W-1:0]   i_wgt_q,
	output logic [AWIDTH-1:0]             o_node_addr,
	output logic [AWIDTH-1:0]             o_wgt_addr,
	output logic                          o_node_ce,
	output logic                          o_wgt_ce,
	output logic                          o_read,
	output logic                          o_read_idle,
	output logic                          o_push,
	output logic                          o_push_last,
	output logic [LANE_W-1:0]             o_push_node,
	output logic [NUM_CORES*LANE_W-1:0]   o_push_wgt
);

	phase_t            rd_phase;
	phase_t            rd_phase_nxt;
	logic [CNT_W-1:0]  num_cnt;
	logic [AWIDTH-1:0] addr_cnt;
	logic              is_read_done;
	logic              r_valid;
	logic              r_last;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_phase <= PH_IDLE;
		end else begin
			rd_phase <= rd_phase_nxt;
		end
	end

	always_comb begin
		rd_phase_nxt = rd_phase;
		case (rd_phase)
			PH_IDLE: if (i_run) rd_phase_nxt = PH_RUN;
			PH_RUN:  if (is_read_done) rd_phase_nxt = PH_DONE;
			PH_DONE: rd_phase_nxt = PH_IDLE;
			default: rd_phase_nxt = PH_IDLE;
		endcase
	end

	assign o_read      = (rd_phase == PH_RUN);
	assign o_read_idle = (rd_phase == PH_IDLE);

	// Count is taken only with an accepted start
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			num_cnt <= '0;
		end else if (i_run && o_read_idle) begin
			num_cnt <= i_num_cnt;
		end
	end

	// Address counter zero-extended for the compare
	assign is_read_done = o_read &&
		({{(CNT_W-AWIDTH){1'b0}}, addr_cnt} == num_cnt - 1'b1);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			addr_cnt <= '0;
		end else if (is_read_done) begin
			addr_cnt <= '0;
		end else if (o_read) begin
			addr_cnt <= addr_cnt + 1'b1;
		end
	end

	// Both memories share one address
	assign o_node_addr = addr_cnt;
	assign o_wgt_addr  = addr_cnt;
	assign o_node_ce   = o_read;
	assign o_wgt_ce    = o_read;

	// One cycle memory latency
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_valid <= 1'b0;
			r_last  <= 1'b0;
		end else begin
			r_valid <= o_read;
			r_last  <= is_read_done;  // Marks address N-1
		end
	end

	assign o_push      = r_valid;
	assign o_push_last = r_last;
	assign o_push_node = i_node_q;  // Valid while o_push is high
	assign o_push_wgt  = i_wgt_q;

endmodule

/* fc_ctrl_pkg.sv */
package fc_ctrl_pkg;

	// Phase of the read and write state machines
	typedef enum logic [1:0] {
		PH_IDLE = 2'b00,
		PH_RUN  = 2'b01,
		PH_DONE = 2'b10
	} phase_t;

endpackage

/* fc_data_pkg.sv */
package fc_data_pkg;

	// Lane and neuron sizing
	localparam int DEF_LANE_W     = 8;   // One node or weight lane
	localparam int DEF_NUM_CORES  = 4;   // Neurons, one weight lane each

	// Four lane widths leave room for long sums
	localparam int DEF_ACC_W      = 32;

	// Memory side
	localparam int DEF_AWIDTH     = 12;
	localparam int DEF_CNT_W      = 13;  // Must exceed DEF_AWIDTH

	// Operand buffer
	localparam int DEF_FIFO_DEPTH = 4;

endpackage
